/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = c16_tb
FILELIST  = c16.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator exits nonzero on $fatal or a failed assertion
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* c16.f */
source/c16_pkg.sv
source/c16_ifs.sv
source/c16_regfile.sv
source/c16_memory.sv
source/c16_fetch.sv
source/c16_decode.sv
source/c16_execute.sv
source/c16_core.sv
verif/c16_properties.sv
verif/c16_tb.sv

/* source/c16_core.sv */
`timescale 1ns/1ps

module c16_core #(
  parameter int mem_addr_w = 10
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               prog_we,
  input  c16_pkg::word_t     prog_addr,
  input  c16_pkg::word_t     prog_data,
  input  c16_pkg::reg_addr_t dbg_addr,
  output c16_pkg::word_t     dbg_value,
  output c16_pkg::word_t     fetch_pc
);
  import c16_pkg::*;

  word_t     next_pc;
  word_t     instruction;
  reg_addr_t wb_dest;
  word_t     wb_value;
  logic      wb_en;
  logic      redirect;
  word_t     redirect_pc;
  word_t     data_addr;
  word_t     data_wdata;
  logic      data_we;
  logic      ld_request;
  reg_addr_t ld_dest;
  logic      ld_en;
  word_t     ld_data;
  logic [mem_addr_w-1:0] instr_addr;

  reg_read_if reg_bus ();
  exec_if     exec_bus ();

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  c16_fetch #(.mem_addr_w(mem_addr_w)) i_fetch (
    .clk, .rst_n, .redirect, .redirect_pc, .next_pc, .fetch_pc
  );

  c16_decode i_decode (
    .clk, .rst_n, .instruction, .fetch_pc, .redirect,
    .reg_port (reg_bus.decoder),
    .exec_bus (exec_bus.source)
  );

  c16_execute i_execute (
    .exec_bus (exec_bus.sink),
    .wb_dest, .wb_value, .wb_en, .redirect, .redirect_pc,
    .data_addr, .data_wdata, .data_we, .ld_request
  );

  // Load data returns one cycle after the address, so rd follows it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_en <= 1'b0;
    end else begin
      ld_en <= ld_request;
    end
    ld_dest <= wb_dest;
  end

  c16_regfile i_regfile (
    .clk, .rst_n, .wb_dest, .wb_value, .wb_en,
    .ld_dest, .ld_data, .ld_en, .dbg_addr,
    .reg_port (reg_bus.regfile),
    .dbg_value
  );

  //////////////////////////////
  // Memory
  //////////////////////////////

  // Program load takes the instruction port while reset is held
  assign instr_addr = prog_we ? prog_addr[mem_addr_w-1:0] : next_pc[mem_addr_w-1:0];

  c16_memory #(.mem_addr_w(mem_addr_w)) i_memory (
    .clk,
    .addr_a  (instr_addr),
    .wdata_a (prog_data),
    .we_a    (prog_we),
    .addr_b  (data_addr[mem_addr_w-1:0]),
    .wdata_b (data_wdata),
    .we_b    (data_we),
    .q_a     (instruction),
    .q_b     (ld_data)
  );

endmodule

/* source/c16_decode.sv */
`timescale 1ns/1ps

module c16_decode (
  input  logic           clk,
  input  logic           rst_n,
  input  c16_pkg::word_t instruction,
  input  c16_pkg::word_t fetch_pc,
  input  logic           redirect,
  reg_read_if.decoder    reg_port,
  exec_if.source         exec_bus
);
  import c16_pkg::*;

  opcode_e   opcode;
  reg_addr_t rd;
  reg_addr_t rs0;
  reg_addr_t rs1;
  word_t     imm5;
  word_t     imm8;

  exec_op_e  op_next;
  word_t     arg_0_next;
  word_t     arg_1_next;
  logic      rd_on_port_1;

  // Low in the first cycle after reset, when q_a holds no fetched word yet
  logic      started;

  //////////////////////////////
  // Field split
  //////////////////////////////

  assign opcode = opcode_e'(instruction[15:11]);
  assign rd     = instruction[10:8];
  assign rs0    = instruction[7:5];
  assign rs1    = instruction[2:0];
  assign imm5   = {{11{instruction[4]}}, instruction[4:0]};
  assign imm8   = {{8{instruction[7]}}, instruction[7:0]};

  // brz tests rd, st stores rd
  assign rd_on_port_1    = opcode inside {brz_i, brz_p, st_i, st_p};
  assign reg_port.addr_0 = rs0;
  assign reg_port.addr_1 = rd_on_port_1 ? rd : rs1;

  //////////////////////////////
  // Operation and operands
  //////////////////////////////

  always_comb begin
    op_next    = op_nop;
    arg_0_next = reg_port.value_0;
    arg_1_next = imm5;
    case (opcode)
      add_i, lea_i: op_next = op_add;
      sub_i:        op_next = op_sub;
      slt_i:        op_next = op_slt;
      shl_i, shl_r: op_next = op_shl;
      call_i:       op_next = op_call;
      ld_i:         op_next = op_ld;
      st_i:         op_next = op_st;
      add_r: begin
        op_next    = op_add;
        arg_1_next = reg_port.value_1;
      end
      sub_r: begin
        op_next    = op_sub;
        arg_1_next = reg_port.value_1;
      end
      slt_r: begin
        op_next    = op_slt;
        arg_1_next = reg_port.value_1;
      end
      lea_p, call_p, ld_p, st_p, brz_p: begin
        arg_0_next = fetch_pc;
        arg_1_next = imm8;
        case (opcode)
          lea_p:   op_next = op_add;
          call_p:  op_next = op_call;
          ld_p:    op_next = op_ld;
          st_p:    op_next = op_st;
          default: op_next = op_brz;
        endcase
      end
      brz_i:        op_next = op_brz;
      default:      op_next = op_nop;
    endcase
    // Branch not taken unless rd is zero
    if (op_next == op_brz && reg_port.value_1 != '0) begin
      op_next = op_nop;
    end
  end

  //////////////////////////////
  // Execute-stage register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started     <= 1'b0;
      exec_bus.op <= op_nop;
    end else begin
      started <= 1'b1;
      // Squash slot behind a taken call or brz
      exec_bus.op <= (redirect || !started) ? op_nop : op_next;
    end
  end

  always_ff @(posedge clk) begin
    exec_bus.arg_0      <= arg_0_next;
    exec_bus.arg_1      <= arg_1_next;
    exec_bus.pc         <= fetch_pc;
    exec_bus.dest       <= rd;
    exec_bus.store_data <= reg_port.value_1;
  end

endmodule

/* source/c16_execute.sv */
`timescale 1ns/1ps

module c16_execute (
  exec_if.sink               exec_bus,
  output c16_pkg::reg_addr_t wb_dest,
  output c16_pkg::word_t     wb_value,
  output logic               wb_en,
  output logic               redirect,
  output c16_pkg::word_t     redirect_pc,
  output c16_pkg::word_t     data_addr,
  output c16_pkg::word_t     data_wdata,
  output logic               data_we,
  output logic               ld_request
);
  import c16_pkg::*;

  word_t sum;

  // Sum doubles as jump target and memory address
  assign sum         = exec_bus.arg_0 + exec_bus.arg_1;
  assign redirect_pc = sum;
  assign data_addr   = sum;
  assign data_wdata  = exec_bus.store_data;
  assign wb_dest     = exec_bus.dest;

  always_comb begin
    wb_value   = sum;
    wb_en      = 1'b0;
    redirect   = 1'b0;
    data_we    = 1'b0;
    ld_request = 1'b0;
    case (exec_bus.op)
      op_add: wb_en = 1'b1;
      op_sub: begin
        wb_value = exec_bus.arg_0 - exec_bus.arg_1;
        wb_en    = 1'b1;
      end
      op_slt: begin
        // Unsigned compare
        wb_value = word_t'(exec_bus.arg_0 < exec_bus.arg_1);
        wb_en    = 1'b1;
      end
      op_shl: begin
        wb_value = exec_bus.arg_0 << exec_bus.arg_1[3:0];
        wb_en    = 1'b1;
      end
      op_call: begin
        wb_value = exec_bus.pc;
        wb_en    = 1'b1;
        redirect = 1'b1;
      end
      op_brz:  redirect   = 1'b1;
      op_ld:   ld_request = 1'b1;
      op_st:   data_we    = 1'b1;
      default: wb_en      = 1'b0;
    endcase
  end

endmodule

/* source/c16_fetch.sv */
`timescale 1ns/1ps

module c16_fetch #(
  parameter int mem_addr_w = 10
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           redirect,
  input  c16_pkg::word_t redirect_pc,
  output c16_pkg::word_t next_pc,
  output c16_pkg::word_t fetch_pc
);
  import c16_pkg::*;

  // Keeps addresses inside the memory depth
  localparam word_t addr_mask = word_t'((32'd1 << mem_addr_w) - 32'd1);

  word_t step_pc;

  assign step_pc = redirect ? redirect_pc : fetch_pc + 16'd1;
  assign next_pc = step_pc & addr_mask;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_pc <= reset_pc;
    end else begin
      fetch_pc <= next_pc;
    end
  end

endmodule

/* source/c16_ifs.sv */
`timescale 1ns/1ps

// Two combinational register reads from decode
interface reg_read_if;
  import c16_pkg::*;

  reg_addr_t addr_0;
  reg_addr_t addr_1;
  word_t     value_0;
  word_t     value_1;

  modport decoder (output addr_0, output addr_1, input value_0, input value_1);
  modport regfile (input addr_0, input addr_1, output value_0, output value_1);
endinterface

// Registered operation handed from decode to execute
interface exec_if;
  import c16_pkg::*;

  exec_op_e  op;
  word_t     arg_0;
  word_t     arg_1;
  word_t     pc;
  reg_addr_t dest;
  word_t     store_data;

  modport source (
    output op, output arg_0, output arg_1,
    output pc, output dest, output store_data
  );
  modport sink (
    input op, input arg_0, input arg_1,
    input pc, input dest, input store_data
  );
endinterface

/* source/c16_memory.sv */
`timescale 1ns/1ps

module c16_memory #(
  parameter int mem_addr_w = 10
) (
  input  logic                  clk,
  input  logic [mem_addr_w-1:0] addr_a,
  input  c16_pkg::word_t        wdata_a,
  input  logic                  we_a,
  input  logic [mem_addr_w-1:0] addr_b,
  input  c16_pkg::word_t        wdata_b,
  input  logic                  we_b,
  output c16_pkg::word_t        q_a,
  output c16_pkg::word_t        q_b
);
  import c16_pkg::*;

  word_t mem [2**mem_addr_w];

  // Both ports read the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (we_a) begin
      mem[addr_a] <= wdata_a;
    end
    if (we_b) begin
      mem[addr_b] <= wdata_b;
    end
    q_a <= mem[addr_a];
    q_b <= mem[addr_b];
  end

endmodule

/* source/c16_pkg.sv */
package c16_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_addr_t;

  // Instruction opcodes, bits [15:11]
  // _i forms take a register plus imm5, _r forms two registers, _p forms pc plus imm8
  typedef enum logic [4:0] {
    add_i  = 5'b00000,
    add_r  = 5'b00001,
    sub_i  = 5'b00010,
    sub_r  = 5'b00011,
    slt_i  = 5'b00100,
    slt_r  = 5'b00101,
    shl_i  = 5'b10000,
    shl_r  = 5'b10001,
    ld_i   = 5'b10100,
    ld_p   = 5'b10101,
    st_i   = 5'b10110,
    st_p   = 5'b10111,
    lea_i  = 5'b11000,
    lea_p  = 5'b11001,
    call_i = 5'b11010,
    call_p = 5'b11011,
    brz_i  = 5'b11110,
    brz_p  = 5'b11111
  } opcode_e;

  // Operations carried from decode to execute
  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_slt  = 4'h2,
    op_shl  = 4'h3,
    op_call = 4'h4,
    op_brz  = 4'h5,
    op_ld   = 4'h6,
    op_st   = 4'h7,
    op_nop  = 4'hf
  } exec_op_e;

  localparam int        num_regs    = 8;
  localparam reg_addr_t discard_reg = 3'd7;
  // First step after reset lands on address 0
  localparam word_t     reset_pc    = 16'hffff;

endpackage

/* source/c16_regfile.sv */
`timescale 1ns/1ps

module c16_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  c16_pkg::reg_addr_t  wb_dest,
  input  c16_pkg::word_t      wb_value,
  input  logic                wb_en,
  input  c16_pkg::reg_addr_t  ld_dest,
  input  c16_pkg::word_t      ld_data,
  input  logic                ld_en,
  input  c16_pkg::reg_addr_t  dbg_addr,
  reg_read_if.regfile         reg_port,
  output c16_pkg::word_t      dbg_value
);
  import c16_pkg::*;

  word_t regs [num_regs];

  // Stored value with this cycle's writes forwarded, load write last so it wins
  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    value = regs[addr];
    if (wb_en && wb_dest == addr && addr != discard_reg) begin
      value = wb_value;
    end
    if (ld_en && ld_dest == addr && addr != discard_reg) begin
      value = ld_data;
    end
    return value;
  endfunction

  always_comb begin
    reg_port.value_0 = read_port(reg_port.addr_0);
    reg_port.value_1 = read_port(reg_port.addr_1);
    dbg_value        = read_port(dbg_addr);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb_en && wb_dest != discard_reg) begin
        regs[wb_dest] <= wb_value;
      end
      // Same target as wb: this later assignment takes effect
      if (ld_en && ld_dest != discard_reg) begin
        regs[ld_dest] <= ld_data;
      end
    end
  end

endmodule

/* verif/c16_properties.sv */
`timescale 1ns/1ps

module c16_properties (
  input logic               clk,
  input logic               rst_n,
  input c16_pkg::reg_addr_t dbg_addr,
  input c16_pkg::word_t     dbg_value
);
  import c16_pkg::*;

  // High on the edge after one that saw rst_n low
  logic in_reset_d = 1'b0;
  // Set once the first reset edge has cleared the registers
  logic reset_seen = 1'b0;

  always @(posedge clk) begin
    in_reset_d <= !rst_n;
    if (!rst_n) begin
      reset_seen <= 1'b1;
    end
  end

  //////////////////////////////
  // Debug read port
  //////////////////////////////

  // Cleared registers during reset and in the cycle after it
  reset_reads_zero: assert property (@(posedge clk) in_reset_d |-> dbg_value == '0)
    else $error("dbg_value %h not zero around reset", $sampled(dbg_value));

  known_after_reset: assert property (
    @(posedge clk) (reset_seen && rst_n) |-> !$isunknown(dbg_value)
  ) else $error("dbg_value unknown after reset");

  // r7 drops every write
  discard_reads_zero: assert property (
    @(posedge clk) (reset_seen && dbg_addr == discard_reg) |-> dbg_value == '0
  ) else $error("r7 reads %h instead of zero", $sampled(dbg_value));

endmodule

/* verif/c16_tb.sv */
`timescale 1ns/1ps

module c16_tb;
  import c16_pkg::*;

  localparam int    clk_period   = 100;
  localparam int    drive_delay  = 1;
  localparam int    reset_cycles = 4;
  localparam int    seed         = 20419;
  localparam int    mem_addr_w   = 10;
  localparam int    data_base    = 100;
  localparam word_t addr_mask    = word_t'((1 << mem_addr_w) - 1);

  logic      clk;
  logic      rst_n;
  logic      prog_we;
  word_t     prog_addr;
  word_t     prog_data;
  reg_addr_t dbg_addr;
  word_t     dbg_value;
  word_t     fetch_pc;

  word_t prog_words [$];
  word_t expect_regs [num_regs];
  word_t loop_pc;
  word_t prev_fetch_pc;

  c16_core #(.mem_addr_w(mem_addr_w)) i_c16_core (
    .clk, .rst_n, .prog_we, .prog_addr, .prog_data, .dbg_addr, .dbg_value, .fetch_pc
  );

  bind c16_core c16_properties i_properties (.clk, .rst_n, .dbg_addr, .dbg_value);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // Program encoding
  //////////////////////////////

  function automatic word_t imm_form(input logic [4:0] op, input reg_addr_t rd,
                                     input reg_addr_t rs0, input logic [4:0] imm);
    return {op, rd, rs0, imm};
  endfunction

  function automatic word_t reg_form(input logic [4:0] op, input reg_addr_t rd,
                                     input reg_addr_t rs0, input reg_addr_t rs1);
    return {op, rd, rs0, 2'b00, rs1};
  endfunction

  function automatic word_t pc_form(input logic [4:0] op, input reg_addr_t rd,
                                    input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [4:0] random_imm5();
    int unsigned value;
    value = $urandom;
    return value[4:0];
  endfunction

  function automatic logic [7:0] random_imm8();
    int unsigned value;
    value = $urandom;
    return value[7:0];
  endfunction

  // pc-relative offset from the word about to be emitted
  function automatic logic [7:0] offset_to(input int target);
    int diff;
    diff = target - prog_words.size();
    return diff[7:0];
  endfunction

  function automatic int settle_cycles();
    return 4 * prog_words.size() + 20;
  endfunction

  task automatic build_program();
    // Arithmetic chain, folded into r3 and r5
    prog_words.push_back(imm_form(add_i, 3'd1, 3'd0, random_imm5()));
    prog_words.push_back(imm_form(add_i, 3'd2, 3'd1, random_imm5()));
    prog_words.push_back(reg_form(add_r, 3'd3, 3'd1, 3'd2));
    prog_words.push_back(imm_form(sub_i, 3'd4, 3'd3, random_imm5()));
    prog_words.push_back(reg_form(sub_r, 3'd5, 3'd4, 3'd1));
    prog_words.push_back(reg_form(slt_r, 3'd6, 3'd1, 3'd2));
    prog_words.push_back(imm_form(slt_i, 3'd0, 3'd5, random_imm5()));
    prog_words.push_back(imm_form(shl_i, 3'd3, 3'd3, random_imm5()));
    prog_words.push_back(imm_form(add_i, 3'd7, 3'd4, random_imm5()));
    prog_words.push_back(reg_form(add_r, 3'd4, 3'd7, 3'd4));
    prog_words.push_back(imm_form(lea_i, 3'd5, 3'd5, random_imm5()));
    prog_words.push_back(reg_form(add_r, 3'd6, 3'd6, 3'd0));
    prog_words.push_back(reg_form(add_r, 3'd3, 3'd3, 3'd4));
    prog_words.push_back(reg_form(add_r, 3'd5, 3'd5, 3'd6));
    // Park both results in data memory
    prog_words.push_back(pc_form(lea_p, 3'd1, offset_to(data_base)));
    prog_words.push_back(imm_form(st_i, 3'd3, 3'd1, 5'd2));
    prog_words.push_back(pc_form(st_p, 3'd5, offset_to(data_base + 10)));
    // Control flow, markers in r6
    prog_words.push_back(pc_form(lea_p, 3'd4, random_imm8()));
    prog_words.push_back(pc_form(call_p, 3'd2, 8'd3));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd1));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd2));
    prog_words.push_back(pc_form(brz_p, 3'd7, 8'd3));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd4));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd8));
    prog_words.push_back(imm_form(brz_i, 3'd2, 3'd0, 5'd0));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd3));
    prog_words.push_back(pc_form(lea_p, 3'd0, 8'd4));
    prog_words.push_back(imm_form(call_i, 3'd3, 3'd0, 5'd0));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'h10));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd9));
    prog_words.push_back(imm_form(brz_i, 3'd7, 3'd0, 5'd3));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd10));
    prog_words.push_back(imm_form(add_i, 3'd6, 3'd6, 5'd11));
    prog_words.push_back(imm_form(5'b01000, 3'd6, 3'd6, 5'd1));
    // Loads back, each with an instruction in its delay slot
    prog_words.push_back(imm_form(ld_i, 3'd5, 3'd1, 5'd2));
    prog_words.push_back(reg_form(add_r, 3'd2, 3'd5, 3'd5));
    prog_words.push_back(pc_form(ld_p, 3'd4, offset_to(data_base + 10)));
    prog_words.push_back(reg_form(add_r, 3'd0, 3'd4, 3'd5));
    prog_words.push_back(pc_form(brz_p, 3'd7, 8'd0));
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // One instruction per step, up to the final self-loop
  task automatic model_program();
    word_t      data_mem [int];
    word_t      instr;
    word_t      a, b, d, imm5, imm8, pc_w, target, result;
    word_t      ld_value, new_value;
    logic [4:0] op;
    reg_addr_t  rd, ld_dest, new_dest;
    logic       write_rd, taken, ld_pending, new_pending;
    int         pc, steps;
    for (int r = 0; r < num_regs; r++) begin
      expect_regs[r] = '0;
    end
    pc = 0;
    steps = 0;
    ld_pending = 1'b0;
    ld_dest = '0;
    ld_value = '0;
    new_dest = '0;
    new_value = '0;
    while (pc != prog_words.size() - 1 && steps < 1000) begin
      instr = prog_words[pc];
      op    = instr[15:11];
      rd    = instr[10:8];
      a     = expect_regs[instr[7:5]];
      b     = expect_regs[instr[2:0]];
      d     = expect_regs[rd];
      imm5  = {{11{instr[4]}}, instr[4:0]};
      imm8  = {{8{instr[7]}}, instr[7:0]};
      pc_w  = word_t'(pc);
      target = (op inside {lea_p, call_p, brz_p, ld_p, st_p}) ? pc_w + imm8 : a + imm5;
      write_rd    = 1'b1;
      taken       = 1'b0;
      new_pending = 1'b0;
      result      = target;
      case (op)
        add_i, lea_i, lea_p: result = target;
        add_r: result = a + b;
        sub_i: result = a - imm5;
        sub_r: result = a - b;
        slt_i: result = (a < imm5) ? 16'd1 : 16'd0;
        slt_r: result = (a < b) ? 16'd1 : 16'd0;
        shl_i: result = a << imm5[3:0];
        call_i, call_p: begin
          result = pc_w;
          taken  = 1'b1;
        end
        brz_i, brz_p: begin
          write_rd = 1'b0;
          taken    = (d == '0);
        end
        ld_i, ld_p: begin
          write_rd    = 1'b0;
          new_pending = 1'b1;
          new_dest    = rd;
          new_value   = data_mem[int'(target & addr_mask)];
        end
        st_i, st_p: begin
          write_rd = 1'b0;
          data_mem[int'(target & addr_mask)] = d;
        end
        default: write_rd = 1'b0;
      endcase
      if (write_rd && rd != discard_reg) begin
        expect_regs[rd] = result;
      end
      // Load from the previous instruction lands now and beats this write
      if (ld_pending && ld_dest != discard_reg) begin
        expect_regs[ld_dest] = ld_value;
      end
      ld_pending = new_pending;
      ld_dest    = new_dest;
      ld_value   = new_value;
      pc = taken ? int'(target & addr_mask) : pc + 1;
      steps++;
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  initial begin : stimulus
    rst_n       = 1'b0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    dbg_addr    = '0;
    void'($urandom(seed));
    build_program();
    model_program();
    for (int i = 0; i < prog_words.size(); i++) begin
      @(posedge clk);
      #drive_delay;
      prog_we   = 1'b1;
      prog_addr = word_t'(i);
      prog_data = prog_words[i];
    end
    @(posedge clk);
    #drive_delay;
    prog_we = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    repeat (settle_cycles()) @(posedge clk);
    // Final brz and its squashed successor take turns in fetch
    loop_pc       = word_t'(prog_words.size() - 1);
    prev_fetch_pc = '0;
    for (int r = 0; r < num_regs; r++) begin
      @(posedge clk);
      #drive_delay;
      dbg_addr = reg_addr_t'(r);
      @(negedge clk);
      assert (dbg_value === expect_regs[r]) else begin
        $display("Fail dbg_value r%0d: got 0x%04h, expected 0x%04h",
                 r, dbg_value, expect_regs[r]);
        $display("Test failed");
        $fatal(1, "Register r%0d differs from the reference model", r);
      end
      assert (fetch_pc === loop_pc || fetch_pc === loop_pc + 16'd1) else begin
        $display("Fail fetch_pc: got 0x%04h, expected 0x%04h or 0x%04h",
                 fetch_pc, loop_pc, loop_pc + 16'd1);
        $display("Test failed");
        $fatal(1, "Core is not looping on the final brz");
      end
      assert (r == 0 || fetch_pc !== prev_fetch_pc) else begin
        $display("Fail fetch_pc: got 0x%04h on two cycles in a row", fetch_pc);
        $display("Test failed");
        $fatal(1, "Final brz is not taken every other cycle");
      end
      prev_fetch_pc = fetch_pc;
    end
    // Keep r7 on dbg_addr across one more edge for the bound checks
    @(posedge clk);
    @(negedge clk);
    $display("Test passed");
    $finish;
  end

  initial begin : watchdog
    #1;
    repeat (2 * settle_cycles()) @(posedge clk);
    $display("Test failed");
    $fatal(1, "Timeout after %0d clock cycles without a result", 2 * settle_cycles());
  end

endmodule
